// ==== all.f ====
scratchpad_pkg.sv
sync_fifo.sv
scratchpad_bank.sv
bank_access_fsm.sv
gemm_feed_fsm.sv
dram_store_fsm.sv
scratchpad.sv
scratchpad_tb.sv

// ==== bank_access_fsm.sv ====
`timescale 1ns/1ps

module bank_access_fsm import scratchpad_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  bank_sel_t  bank_id,
    input  instr_t     head,
    input  logic       head_empty,
    output logic       head_release,
    output bank_cmd_t  cmd,
    input  logic       gemm_full,
    input  logic       store_full,
    output logic       load_req,
    output dram_addr_t load_addr,
    input  logic       load_ack,
    input  row_t       load_data,
    output logic       load_complete
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD_REQ,
        LOAD_WAIT_LOW,
        READ_ROWS,
        DONE
    } state_e;

    state_e     state;
    state_e     next_state;
    row_idx_t   row_cnt;
    logic       served;
    logic       mine;
    logic       is_gemm;
    logic       queue_full;
    logic       last_row;
    dram_addr_t row_addr;

    assign mine       = !head_empty && (head.bank == bank_id) && (head.opcode != OP_NOP);
    assign is_gemm    = (head.opcode == OP_GEMM);
    assign queue_full = is_gemm ? gemm_full : store_full;
    assign last_row   = (row_cnt == row_idx_t'(MAT_ROWS - 1));
    assign row_addr   = head.dram_addr + dram_addr_t'(row_cnt);

    // Other banks' instructions pass straight through
    assign head_release = !mine || served;

    assign load_req  = (state == LOAD_REQ);
    assign load_addr = load_req ? row_addr : '0;

    always_comb begin
        next_state  = state;
        cmd         = '0;
        cmd.addr    = {head.slot, row_cnt};
        cmd.to_gemm = is_gemm;
        cmd.wdata   = load_data;
        cmd.tag     = is_gemm ? dram_addr_t'(head.weight) : row_addr;
        case (state)
            IDLE: begin
                if (mine) begin
                    next_state = (head.opcode == OP_LOAD) ? LOAD_REQ : READ_ROWS;
                end
            end
            LOAD_REQ: begin
                if (load_ack) begin
                    cmd.wen    = 1'b1;
                    next_state = LOAD_WAIT_LOW;
                end
            end
            LOAD_WAIT_LOW: begin
                if (!load_ack) begin
                    next_state = last_row ? DONE : LOAD_REQ;
                end
            end
            READ_ROWS: begin
                // Stall on a full output queue
                if (!queue_full) begin
                    cmd.ren = 1'b1;
                    if (last_row) begin
                        next_state = DONE;
                    end
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state         <= IDLE;
            row_cnt       <= '0;
            served        <= 1'b0;
            load_complete <= 1'b0;
        end else begin
            state         <= next_state;
            served        <= (next_state == DONE);
            load_complete <= (state == LOAD_REQ) && load_ack && last_row;
            if (state == IDLE) begin
                row_cnt <= '0;
            end else if ((state == LOAD_WAIT_LOW && !load_ack) || cmd.ren) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // Request holds until acknowledged
    assert property (@(posedge CLK) disable iff (!nRST) load_req && !load_ack |=> load_req)
        else $error("bank_access_fsm: load_req dropped before load_ack");

endmodule

// ==== dram_store_fsm.sv ====
`timescale 1ns/1ps

module dram_store_fsm import scratchpad_pkg::*; (
    input  logic                          CLK,
    input  logic                          nRST,
    input  store_entry_t [NUM_BANKS-1:0]  heads,
    input  logic [NUM_BANKS-1:0]          empties,
    output logic [NUM_BANKS-1:0]          rens,
    output logic                          store_req,
    output dram_addr_t                    store_addr,
    output row_t                          store_data,
    input  logic                          store_ack,
    output logic                          store_complete
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_LOW
    } state_e;

    state_e       state;
    bank_sel_t    sel;
    store_entry_t cur;
    logic         pop;

    assign cur = heads[sel];

    // Head stays put until popped, so address and data hold during req
    assign store_req  = (state == REQ) && !empties[sel];
    assign store_addr = cur.dram_addr;
    assign store_data = cur.row;

    // Pop once ack has fallen
    assign pop = (state == WAIT_LOW) && !store_ack;

    always_comb begin
        rens      = '0;
        rens[sel] = pop;
    end

    assign store_complete = pop && cur.last;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            sel   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!(&empties)) begin
                        sel   <= lowest_bank(~empties);
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (store_req && store_ack) begin
                        state <= WAIT_LOW;
                    end
                end
                WAIT_LOW: begin
                    if (!store_ack) begin
                        state <= cur.last ? IDLE : REQ;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== gemm_feed_fsm.sv ====
`timescale 1ns/1ps

module gemm_feed_fsm import scratchpad_pkg::*; (
    input  logic                          CLK,
    input  logic                          nRST,
    input  gemm_entry_t [NUM_BANKS-1:0]   heads,
    input  logic [NUM_BANKS-1:0]          empties,
    output logic [NUM_BANKS-1:0]          rens,
    input  logic                          array_space,
    output logic                          weight_enable,
    output logic                          input_enable,
    output row_t                          row_data,
    output row_idx_t                      row_sel,
    output logic                          gemm_complete
);

    typedef enum logic {
        FEED_IDLE,
        FEED_STREAM
    } state_e;

    state_e      state;
    bank_sel_t   sel;
    gemm_entry_t cur;
    logic        fire;

    assign cur  = heads[sel];
    assign fire = (state == FEED_STREAM) && array_space && !empties[sel];

    always_comb begin
        rens      = '0;
        rens[sel] = fire;
    end

    assign weight_enable = fire && cur.weight;
    assign input_enable  = fire && !cur.weight;
    assign row_data      = fire ? cur.row : '0;
    assign row_sel       = fire ? cur.row_idx : '0;
    assign gemm_complete = fire && cur.last;

    // Stay on one bank until its matrix is out
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= FEED_IDLE;
            sel   <= '0;
        end else begin
            case (state)
                FEED_IDLE: begin
                    if (!(&empties)) begin
                        sel   <= lowest_bank(~empties);
                        state <= FEED_STREAM;
                    end
                end
                FEED_STREAM: begin
                    if (fire && cur.last) begin
                        state <= FEED_IDLE;
                    end
                end
                default: begin
                    state <= FEED_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== scratchpad.sv ====
`timescale 1ns/1ps

module scratchpad import scratchpad_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       instr_wen,
    input  instr_t     instr,
    output logic       instr_full,
    output logic       load_req,
    output dram_addr_t load_addr,
    input  logic       load_ack,
    input  row_t       load_data,
    output logic       load_complete,
    output logic       store_req,
    output dram_addr_t store_addr,
    output row_t       store_data,
    input  logic       store_ack,
    output logic       store_complete,
    input  logic       array_space,
    output logic       weight_enable,
    output logic       input_enable,
    output row_t       row_data,
    output row_idx_t   row_sel,
    output logic       gemm_complete
);

    instr_t                        head;
    logic                          head_empty;
    logic                          head_pop;
    logic [NUM_BANKS-1:0]          releases;
    logic [NUM_BANKS-1:0]          load_reqs;
    logic [NUM_BANKS-1:0]          load_completes;
    dram_addr_t [NUM_BANKS-1:0]    load_addrs;
    bank_cmd_t [NUM_BANKS-1:0]     cmds;
    gemm_entry_t [NUM_BANKS-1:0]   gemm_heads;
    store_entry_t [NUM_BANKS-1:0]  store_heads;
    logic [NUM_BANKS-1:0]          gemm_rens;
    logic [NUM_BANKS-1:0]          store_rens;
    logic [NUM_BANKS-1:0]          gemm_empties;
    logic [NUM_BANKS-1:0]          store_empties;
    logic [NUM_BANKS-1:0]          gemm_fulls;
    logic [NUM_BANKS-1:0]          store_fulls;

    sync_fifo #(.DEPTH(INSTRQ_DEPTH), .T(instr_t)) instr_q (
        .CLK(CLK), .nRST(nRST),
        .wen(instr_wen), .ren(head_pop), .wdata(instr), .rdata(head),
        .full(instr_full), .empty(head_empty)
    );

    // Head leaves only when every controller is done with it
    assign head_pop = (&releases) && !head_empty;

    // Only one controller loads at a time
    assign load_req      = |load_reqs;
    assign load_addr     = load_addrs[lowest_bank(load_reqs)];
    assign load_complete = |load_completes;

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        scratchpad_bank bank (
            .CLK(CLK), .nRST(nRST),
            .cmd(cmds[g]),
            .gemm_ren(gemm_rens[g]), .store_ren(store_rens[g]),
            .gemm_head(gemm_heads[g]), .store_head(store_heads[g]),
            .gemm_empty(gemm_empties[g]), .store_empty(store_empties[g]),
            .gemm_full(gemm_fulls[g]), .store_full(store_fulls[g])
        );

        bank_access_fsm ctrl (
            .CLK(CLK), .nRST(nRST),
            .bank_id(bank_sel_t'(g)),
            .head(head), .head_empty(head_empty), .head_release(releases[g]),
            .cmd(cmds[g]),
            .gemm_full(gemm_fulls[g]), .store_full(store_fulls[g]),
            .load_req(load_reqs[g]), .load_addr(load_addrs[g]),
            .load_ack(load_ack), .load_data(load_data),
            .load_complete(load_completes[g])
        );
    end

    gemm_feed_fsm gemm_feed (
        .CLK(CLK), .nRST(nRST),
        .heads(gemm_heads), .empties(gemm_empties), .rens(gemm_rens),
        .array_space(array_space),
        .weight_enable(weight_enable), .input_enable(input_enable),
        .row_data(row_data), .row_sel(row_sel), .gemm_complete(gemm_complete)
    );

    dram_store_fsm dram_store (
        .CLK(CLK), .nRST(nRST),
        .heads(store_heads), .empties(store_empties), .rens(store_rens),
        .store_req(store_req), .store_addr(store_addr), .store_data(store_data),
        .store_ack(store_ack), .store_complete(store_complete)
    );

endmodule

// ==== scratchpad_bank.sv ====
`timescale 1ns/1ps

module scratchpad_bank import scratchpad_pkg::*; (
    input  logic         CLK,
    input  logic         nRST,
    input  bank_cmd_t    cmd,
    input  logic         gemm_ren,
    input  logic         store_ren,
    output gemm_entry_t  gemm_head,
    output store_entry_t store_head,
    output logic         gemm_empty,
    output logic         store_empty,
    output logic         gemm_full,
    output logic         store_full
);

    row_t mem [MATS_PER_BANK*MAT_ROWS];

    row_t         rd_row;
    dram_addr_t   rd_tag;
    row_idx_t     rd_idx;
    logic         rd_gemm;
    logic         rd_valid;
    logic         rd_last;
    logic         gemm_push;
    logic         store_push;
    logic         gemm_q_full;
    logic         store_q_full;
    gemm_entry_t  gemm_in;
    store_entry_t store_in;

    always_ff @(posedge CLK) begin
        if (cmd.wen) begin
            mem[cmd.addr] <= cmd.wdata;
        end
        if (cmd.ren) begin
            rd_row  <= mem[cmd.addr];
            rd_tag  <= cmd.tag;
            rd_idx  <= row_idx_t'(cmd.addr);
            rd_gemm <= cmd.to_gemm;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= cmd.ren;
        end
    end

    assign rd_last    = (rd_idx == row_idx_t'(MAT_ROWS - 1));
    assign gemm_push  = rd_valid && rd_gemm;
    assign store_push = rd_valid && !rd_gemm;

    assign gemm_in.row     = rd_row;
    assign gemm_in.row_idx = rd_idx;
    assign gemm_in.weight  = rd_tag[0];
    assign gemm_in.last    = rd_last;

    assign store_in.row       = rd_row;
    assign store_in.dram_addr = rd_tag;
    assign store_in.last      = rd_last;

    // Count the read in flight as occupied space
    assign gemm_full  = gemm_q_full || gemm_push;
    assign store_full = store_q_full || store_push;

    sync_fifo #(.DEPTH(OUTQ_DEPTH), .T(gemm_entry_t)) gemm_q (
        .CLK(CLK), .nRST(nRST),
        .wen(gemm_push), .ren(gemm_ren), .wdata(gemm_in), .rdata(gemm_head),
        .full(gemm_q_full), .empty(gemm_empty)
    );

    sync_fifo #(.DEPTH(OUTQ_DEPTH), .T(store_entry_t)) store_q (
        .CLK(CLK), .nRST(nRST),
        .wen(store_push), .ren(store_ren), .wdata(store_in), .rdata(store_head),
        .full(store_q_full), .empty(store_empty)
    );

    assert property (@(posedge CLK) disable iff (!nRST)
        cmd.ren |-> !(cmd.to_gemm ? gemm_full : store_full))
        else $error("scratchpad_bank: read issued to a full queue");

endmodule

// ==== scratchpad_pkg.sv ====
package scratchpad_pkg;

    localparam int NUM_BANKS     = 4;
    localparam int MAT_ROWS      = 4;
    localparam int MATS_PER_BANK = 4;
    localparam int ROW_W         = 32;
    localparam int DRAM_AW       = 16;
    localparam int OUTQ_DEPTH    = 4;
    localparam int INSTRQ_DEPTH  = 4;

    // Four 8-bit elements per row
    typedef logic [ROW_W-1:0]   row_t;
    typedef logic [DRAM_AW-1:0] dram_addr_t;
    typedef logic [1:0]         bank_sel_t;
    typedef logic [1:0]         slot_t;
    typedef logic [1:0]         row_idx_t;
    // {slot, row}
    typedef logic [3:0]         bank_addr_t;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2,
        OP_GEMM  = 2'd3
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        bank_sel_t  bank;
        slot_t      slot;
        logic       weight;
        dram_addr_t dram_addr;
        logic [8:0] rsvd;
    } instr_t;

    // Tag holds the DRAM row address for stores and the gemm weight flag in bit 0
    typedef struct packed {
        logic       wen;
        logic       ren;
        logic       to_gemm;
        bank_addr_t addr;
        row_t       wdata;
        dram_addr_t tag;
    } bank_cmd_t;

    typedef struct packed {
        row_t     row;
        row_idx_t row_idx;
        logic     weight;
        logic     last;
    } gemm_entry_t;

    typedef struct packed {
        row_t       row;
        dram_addr_t dram_addr;
        logic       last;
    } store_entry_t;

    // Index of the lowest set flag or 0 when none is set
    function automatic bank_sel_t lowest_bank(logic [NUM_BANKS-1:0] flags);
        bank_sel_t idx;
        idx = '0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            if (flags[i]) begin
                idx = bank_sel_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

// ==== scratchpad_tb.sv ====
`timescale 1ns/1ps

module scratchpad_tb import scratchpad_pkg::*; ();

    localparam int CLK_PERIOD      = 8;
    localparam int CYCLES_PER_STEP = 200;
    localparam logic [31:0] SEED   = 32'h180f_f919;

    typedef struct packed {
        logic [3:0] test;
        opcode_e    op;
        bank_sel_t  bank;
        slot_t      slot;
        logic       weight;
        dram_addr_t addr;
        logic       space_rand;
    } step_t;

    typedef struct packed {
        row_t [MAT_ROWS-1:0] rows;
        logic                weight;
    } mat_t;

    logic       CLK;
    logic       nRST;
    logic       instr_wen;
    instr_t     instr;
    logic       instr_full;
    logic       load_req;
    dram_addr_t load_addr;
    logic       load_ack;
    row_t       load_data;
    logic       load_complete;
    logic       store_req;
    dram_addr_t store_addr;
    row_t       store_data;
    logic       store_ack;
    logic       store_complete;
    logic       array_space;
    logic       weight_enable;
    logic       input_enable;
    row_t       row_data;
    row_idx_t   row_sel;
    logic       gemm_complete;

    step_t      steps[$];
    mat_t       exp_mats[$];
    dram_addr_t store_addrs[$];
    row_t       dram_mem [dram_addr_t];
    row_t       exp_dram [dram_addr_t];
    row_t       bank_model [NUM_BANKS][MATS_PER_BANK][MAT_ROWS];

    int checks, errors, test_chk0, test_err0;
    int exp_loads, exp_stores, exp_gemms;
    int seen_loads, seen_stores, seen_gemms;
    int load_delay, store_delay, space_bit, obs_rows;
    logic [31:0] load_lfsr, store_lfsr, space_lfsr;
    logic space_rand_mode, mat_found;
    logic prev_load_req, prev_load_ack, prev_store_req, prev_store_ack;
    dram_addr_t prev_store_addr;
    row_t prev_store_data;
    mat_t obs_mat;

    scratchpad dut0 (
        .CLK(CLK), .nRST(nRST),
        .instr_wen(instr_wen), .instr(instr), .instr_full(instr_full),
        .load_req(load_req), .load_addr(load_addr), .load_ack(load_ack),
        .load_data(load_data), .load_complete(load_complete),
        .store_req(store_req), .store_addr(store_addr), .store_data(store_data),
        .store_ack(store_ack), .store_complete(store_complete),
        .array_space(array_space),
        .weight_enable(weight_enable), .input_enable(input_enable),
        .row_data(row_data), .row_sel(row_sel), .gemm_complete(gemm_complete)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(inout logic [31:0] state, input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            value = (value << 1) | state[0];
        end
    endtask

    // Unique DRAM contents for every address
    function automatic row_t pattern(dram_addr_t a);
        return {a ^ 16'hc3a5, a * 16'd7 + 16'h0b1d};
    endfunction

    function automatic string test_name(int t);
        case (t)
            1: return "after_reset";
            2: return "load_store_round_trip";
            3: return "gemm_streaming";
            4: return "array_back_pressure";
            5: return "four_phase_discipline";
            default: return "bank_independence";
        endcase
    endfunction

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_step(input int test, input opcode_e op, input int bank, input int slot,
                            input logic weight, input dram_addr_t addr, input logic space_rand);
        step_t s;
        s.test       = 4'(test);
        s.op         = op;
        s.bank       = bank_sel_t'(bank);
        s.slot       = slot_t'(slot);
        s.weight     = weight;
        s.addr       = addr;
        s.space_rand = space_rand;
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_step(2, OP_LOAD,  0, 1, 1'b0, 16'h0100, 1'b0);
        add_step(2, OP_STORE, 0, 1, 1'b0, 16'h2000, 1'b0);
        add_step(3, OP_GEMM,  0, 1, 1'b1, 16'h0000, 1'b0);
        add_step(3, OP_GEMM,  0, 1, 1'b0, 16'h0000, 1'b0);
        add_step(4, OP_LOAD,  1, 2, 1'b0, 16'h0340, 1'b0);
        add_step(4, OP_GEMM,  1, 2, 1'b0, 16'h0000, 1'b1);
        add_step(4, OP_GEMM,  1, 2, 1'b1, 16'h0000, 1'b1);
        add_step(5, OP_LOAD,  3, 0, 1'b0, 16'h0a00, 1'b0);
        add_step(5, OP_STORE, 3, 0, 1'b0, 16'h2100, 1'b0);
        add_step(5, OP_STORE, 3, 0, 1'b0, 16'h2200, 1'b0);
        // Same slot in every bank so only the data tells them apart
        add_step(6, OP_LOAD,  0, 3, 1'b0, 16'h1000, 1'b0);
        add_step(6, OP_LOAD,  1, 3, 1'b0, 16'h1100, 1'b0);
        add_step(6, OP_LOAD,  2, 3, 1'b0, 16'h1200, 1'b0);
        add_step(6, OP_LOAD,  3, 3, 1'b0, 16'h1300, 1'b0);
        add_step(6, OP_STORE, 2, 3, 1'b0, 16'h3000, 1'b0);
        add_step(6, OP_GEMM,  3, 3, 1'b1, 16'h0000, 1'b0);
        add_step(6, OP_STORE, 1, 3, 1'b0, 16'h3100, 1'b0);
        add_step(6, OP_GEMM,  0, 3, 1'b0, 16'h0000, 1'b0);
        add_step(6, OP_STORE, 0, 3, 1'b0, 16'h3200, 1'b0);
        add_step(6, OP_GEMM,  2, 3, 1'b1, 16'h0000, 1'b0);
        add_step(6, OP_STORE, 3, 3, 1'b0, 16'h3300, 1'b0);
        add_step(6, OP_GEMM,  1, 3, 1'b0, 16'h0000, 1'b0);
    endtask

    // Update the reference model in issue order, then push to the queue
    task automatic apply_step(input step_t s);
        instr_t     ins;
        mat_t       m;
        dram_addr_t a;
        ins           = '0;
        ins.opcode    = s.op;
        ins.bank      = s.bank;
        ins.slot      = s.slot;
        ins.weight    = s.weight;
        ins.dram_addr = s.addr;
        if (s.space_rand) begin
            space_rand_mode = 1'b1;
        end
        for (int r = 0; r < MAT_ROWS; r++) begin
            a = dram_addr_t'(s.addr + r);
            if (s.op == OP_LOAD) begin
                bank_model[s.bank][s.slot][r] = pattern(a);
            end else if (s.op == OP_STORE) begin
                exp_dram[a] = bank_model[s.bank][s.slot][r];
                store_addrs.push_back(a);
            end
            m.rows[r] = bank_model[s.bank][s.slot][r];
        end
        m.weight = s.weight;
        case (s.op)
            OP_LOAD:  exp_loads++;
            OP_STORE: exp_stores++;
            OP_GEMM: begin
                exp_gemms++;
                exp_mats.push_back(m);
            end
            default: ;
        endcase
        @(posedge CLK);
        while (instr_full) begin
            @(posedge CLK);
        end
        instr     <= ins;
        instr_wen <= 1'b1;
        @(posedge CLK);
        instr_wen <= 1'b0;
    endtask

    task automatic finish_test(input int t);
        dram_addr_t a;
        while (seen_loads < exp_loads || seen_stores < exp_stores || seen_gemms < exp_gemms) begin
            @(negedge CLK);
        end
        repeat (4) @(negedge CLK);
        expect_equal(seen_loads, exp_loads, "load_complete count");
        expect_equal(seen_stores, exp_stores, "store_complete count");
        expect_equal(seen_gemms, exp_gemms, "gemm_complete count");
        expect_equal(exp_mats.size(), 0, "issued gemm matrices left unstreamed");
        while (store_addrs.size() > 0) begin
            a = store_addrs.pop_front();
            expect_equal(dram_mem.exists(a), 1'b1, $sformatf("store reached DRAM row %h", a));
            if (dram_mem.exists(a)) begin
                expect_equal(dram_mem[a], exp_dram[a], $sformatf("DRAM row %h", a));
            end
        end
        space_rand_mode = 1'b0;
        $display("[test %0d] %s: %0d checks, %0d errors", t, test_name(t),
                 checks - test_chk0, errors - test_err0);
        test_chk0 = checks;
        test_err0 = errors;
    endtask

    initial begin
        nRST            = 1'b0;
        instr_wen       = 1'b0;
        instr           = '0;
        load_ack        = 1'b0;
        load_data       = '0;
        store_ack       = 1'b0;
        array_space     = 1'b1;
        load_lfsr       = SEED;
        store_lfsr      = SEED;
        space_lfsr      = SEED;
        space_rand_mode = 1'b0;
        build_table();
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        expect_equal({load_req, store_req, weight_enable, input_enable}, 4'b0,
                     "requests after reset");
        expect_equal({load_complete, store_complete, gemm_complete}, 3'b0, "completes after reset");
        expect_equal(instr_full, 1'b0, "instr_full after reset");
        $display("[test 1] %s: %0d checks, %0d errors", test_name(1), checks, errors);
        test_chk0 = checks;
        test_err0 = errors;
        for (int i = 0; i < steps.size(); i++) begin
            if (i > 0 && steps[i].test != steps[i-1].test) begin
                finish_test(steps[i-1].test);
            end
            apply_step(steps[i]);
        end
        finish_test(steps[steps.size()-1].test);
        $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        forever begin
            @(posedge CLK);
            if (nRST && load_req && !load_ack) begin
                take_bits(load_lfsr, 2, load_delay);
                repeat (load_delay) @(posedge CLK);
                load_data <= pattern(load_addr);
                load_ack  <= 1'b1;
                do begin
                    @(posedge CLK);
                end while (load_req);
                load_ack <= 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(posedge CLK);
            if (nRST && store_req && !store_ack) begin
                take_bits(store_lfsr, 2, store_delay);
                repeat (store_delay) @(posedge CLK);
                dram_mem[store_addr] = store_data;
                store_ack <= 1'b1;
                do begin
                    @(posedge CLK);
                end while (store_req);
                store_ack <= 1'b0;
            end
        end
    end

    always @(posedge CLK) begin
        if (space_rand_mode) begin
            take_bits(space_lfsr, 1, space_bit);
            array_space <= space_bit[0];
        end else begin
            array_space <= 1'b1;
        end
    end

    // Handshake rules and completion counts
    always @(posedge CLK) begin
        if (nRST) begin
            if (prev_load_req && !prev_load_ack) begin
                expect_equal(load_req, 1'b1, "load_req held until load_ack");
            end
            if (prev_store_req && !prev_store_ack) begin
                expect_equal(store_req, 1'b1, "store_req held until store_ack");
            end
            if (prev_store_req && store_req) begin
                expect_equal(store_addr, prev_store_addr, "store_addr stable during req");
                expect_equal(store_data, prev_store_data, "store_data stable during req");
            end
            seen_loads  += load_complete;
            seen_stores += store_complete;
        end
        prev_load_req   = load_req;
        prev_load_ack   = load_ack;
        prev_store_req  = store_req;
        prev_store_ack  = store_ack;
        prev_store_addr = store_addr;
        prev_store_data = store_data;
    end

    // Collect each streamed matrix and match it to an issued gemm
    always @(posedge CLK) begin
        if (nRST && (weight_enable || input_enable)) begin
            expect_equal(weight_enable && input_enable, 1'b0, "both enables at once");
            expect_equal(array_space, 1'b1, "enable without array_space");
            expect_equal(row_sel, obs_rows, "row_sel order");
            expect_equal(gemm_complete, obs_rows == MAT_ROWS - 1, "gemm_complete with last row");
            if (obs_rows == 0) begin
                obs_mat.weight = weight_enable;
            end else begin
                expect_equal(weight_enable, obs_mat.weight, "enable kind within a matrix");
            end
            obs_mat.rows[obs_rows] = row_data;
            if (obs_rows == MAT_ROWS - 1) begin
                mat_found = 1'b0;
                for (int i = 0; i < exp_mats.size(); i++) begin
                    if (!mat_found && exp_mats[i] == obs_mat) begin
                        exp_mats.delete(i);
                        mat_found = 1'b1;
                    end
                end
                expect_equal(mat_found, 1'b1, "streamed matrix matches an issued gemm");
                seen_gemms += gemm_complete;
                obs_rows = 0;
            end else begin
                obs_rows++;
            end
        end else if (nRST && gemm_complete) begin
            expect_equal(gemm_complete, 1'b0, "gemm_complete without an enable");
        end
    end

    initial begin
        @(posedge nRST);
        repeat (steps.size() * CYCLES_PER_STEP) @(posedge CLK);
        $display("Timeout: the run did not finish within %0d cycles",
                 steps.size() * CYCLES_PER_STEP);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = logic
) (
    input  logic CLK,
    input  logic nRST,
    input  logic wen,
    input  logic ren,
    input  T     wdata,
    output T     rdata,
    output logic full,
    output logic empty
);

    T mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wptr;
    logic [$clog2(DEPTH)-1:0]   rptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic do_wr;
    logic do_rd;

    assign do_wr = wen && !full;
    assign do_rd = ren && !empty;
    assign full  = (count == DEPTH);
    assign empty = (count == '0);

    // Head is visible without a read strobe
    assign rdata = mem[rptr];

    always_ff @(posedge CLK) begin
        if (do_wr) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wptr <= (wptr == DEPTH - 1) ? '0 : wptr + 1'b1;
            end
            if (do_rd) begin
                rptr <= (rptr == DEPTH - 1) ? '0 : rptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) !(wen && full) && !(ren && empty))
        else $error("sync_fifo: write while full or read while empty");

endmodule
